//--- excp_defs.svh
`ifndef EXCP_DEFS_SVH
`define EXCP_DEFS_SVH

// ******************************
// Widths
// ******************************

`define XLEN     32     // Data and address width
`define IS_W     13     // Interrupt status and enable vector width

// Positions inside the interrupt status vector
`define TI_BIT   11     // Timer interrupt
`define HWI_LSB  2      // Hardware interrupts occupy HWI_LSB up to HWI_LSB + 7

// ******************************
// CSR numbers
// ******************************

// On APB the CSR number is the word address, paddr[15:2]
`define CSR_CRMD       14'h000
`define CSR_PRMD       14'h001
`define CSR_ECFG       14'h004
`define CSR_ESTAT      14'h005
`define CSR_ERA        14'h006
`define CSR_BADV       14'h007
`define CSR_EENTRY     14'h00c
`define CSR_TLBRENTRY  14'h088

`endif

//--- excp_pkg.sv
`include "excp_defs.svh"

package excp_pkg;

    // ******************************
    // Basic types
    // ******************************

    typedef logic [`XLEN-1:0] virt_t;

    typedef enum logic [1:0] {
        KERNEL = 2'd0,
        USER   = 2'd3
    } plv_t;

    // Upper 9 bits are the subcode, lower 6 bits the code
    typedef enum logic [14:0] {
        INT  = 15'h0000,
        PIL  = 15'h0001,
        PIS  = 15'h0002,
        PIF  = 15'h0003,
        ADE  = 15'h0008,
        ALE  = 15'h0009,
        SYS  = 15'h000b,
        BRK  = 15'h000c,
        INE  = 15'h000d,
        TLBR = 15'h003f
    } ecode_t;

    // ******************************
    // CSR layouts
    // ******************************

    typedef struct packed {
        logic [28:0] r0;                        // Paging and memory-type fields not modelled
        logic        ie;
        plv_t        plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] r0;
        logic        pie;
        plv_t        pplv;
    } prmd_t;

    typedef struct packed {
        logic              r0;
        ecode_t            r_esubcode_ecode;
        logic [2:0]        r1;
        logic [`IS_W-1:0]  is;
    } estat_t;

    typedef struct packed {
        logic [`XLEN-`IS_W-1:0] r0;
        logic [`IS_W-1:0]       lie;            // Local interrupt enables, one per status bit
    } ecfg_t;

    // One CSR data word seen through each register layout
    typedef union packed {
        logic [`XLEN-1:0] raw;
        crmd_t            crmd;
        prmd_t            prmd;
        estat_t           estat;
        ecfg_t            ecfg;
    } csr_word_u;

    typedef struct packed {
        crmd_t  crmd;
        prmd_t  prmd;
        ecfg_t  ecfg;
        estat_t estat;
        virt_t  era;
        virt_t  badv;
        virt_t  eentry;
        virt_t  tlbrentry;
    } csr_t;

    // ******************************
    // Requests
    // ******************************

    typedef struct packed {
        logic   valid;
        ecode_t esubcode_ecode;
    } excp_pass_t;

    typedef struct packed {
        logic       valid;                      // Instruction present, may still be a bubble
        virt_t      epc;
        excp_pass_t excp_pass;
    } excp_req_t;

    typedef struct packed {
        logic  valid;
        virt_t pc;
    } wr_pc_req_t;

    typedef struct packed {
        logic   we;
        crmd_t  crmd;
        prmd_t  prmd;
        estat_t estat;
        virt_t  era;
    } excp_wr_csr_req_t;

endpackage

//--- retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  retire_valid,
    input  excp_pkg::virt_t       retire_pc,
    input  excp_pkg::excp_pass_t  retire_excp,
    input  logic                  excp_flush,
    output excp_pkg::excp_req_t   req
);

    logic             valid_q;
    logic             excp_valid_q;
    excp_pkg::virt_t  pc_q;
    excp_pkg::ecode_t ecode_q;
    logic             take;

    // An instruction arriving during a flush is younger than the trapping one
    assign take = retire_valid & ~excp_flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q      <= 1'b0;
            excp_valid_q <= 1'b0;
        end else begin
            valid_q      <= take;
            excp_valid_q <= take & retire_excp.valid;   // A bubble never carries an exception
        end
    end

    always_ff @(posedge clk) begin
        pc_q    <= retire_pc;
        ecode_q <= retire_excp.esubcode_ecode;
    end

    always_comb begin
        req.valid                    = valid_q;
        req.epc                      = pc_q;
        req.excp_pass.valid          = excp_valid_q;
        req.excp_pass.esubcode_ecode = ecode_q;
    end

endmodule

//--- excp_unit.sv
`timescale 1ns/1ps
`include "excp_defs.svh"

module excp_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ti_in,
    input  logic                        ti_clr,
    input  logic [7:0]                  hwi_in,
    input  excp_pkg::excp_req_t         req,
    input  excp_pkg::csr_t              rd_csr,
    output excp_pkg::wr_pc_req_t        wr_pc_req,
    output logic                        excp_flush,
    output excp_pkg::excp_wr_csr_req_t  wr_csr_req,
    output logic [`IS_W-1:0]            is
);

    logic [`IS_W-1:0] int_set;
    logic [`IS_W-1:0] is_q;
    logic             is_int;
    logic             is_excp;
    logic             to_tlbr;

    // ******************************
    // Interrupt status
    // ******************************

    // Software bits and the IPI bit are never raised here
    always_comb begin
        int_set                  = '0;
        int_set[`HWI_LSB +: 8]   = hwi_in;
        int_set[`TI_BIT]         = ti_in;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            is_q <= '0;
        end else begin
            is_q <= is_q | int_set;             // Sticky until software clears them
            if (ti_clr) begin
                is_q[`TI_BIT] <= 1'b0;          // Clear beats a timer tick in the same cycle
            end
        end
    end

    assign is = is_q;

    // ******************************
    // Decision
    // ******************************

    assign is_int  = req.valid & rd_csr.crmd.ie & (|(is_q & rd_csr.ecfg.lie));
    assign is_excp = req.excp_pass.valid;

    assign excp_flush = is_int | is_excp;

    // An interrupt always goes to EENTRY even if the instruction also took a refill
    assign to_tlbr = is_excp & ~is_int &
                     (req.excp_pass.esubcode_ecode == excp_pkg::TLBR);

    assign wr_pc_req.valid = excp_flush;
    assign wr_pc_req.pc    = to_tlbr ? rd_csr.tlbrentry : rd_csr.eentry;

    // ******************************
    // CSR update
    // ******************************

    always_comb begin
        wr_csr_req.we    = excp_flush;
        wr_csr_req.crmd  = rd_csr.crmd;
        wr_csr_req.prmd  = rd_csr.prmd;
        wr_csr_req.estat = rd_csr.estat;
        wr_csr_req.era   = rd_csr.era;
        if (excp_flush) begin
            wr_csr_req.crmd.plv  = excp_pkg::KERNEL;
            wr_csr_req.crmd.ie   = 1'b0;
            wr_csr_req.prmd.pplv = rd_csr.crmd.plv;     // Saved for the return path
            wr_csr_req.prmd.pie  = rd_csr.crmd.ie;
            wr_csr_req.era       = req.epc;
            wr_csr_req.estat.r_esubcode_ecode = is_int ? excp_pkg::INT
                                                       : req.excp_pass.esubcode_ecode;
        end
    end

endmodule

//--- csr_file.sv
`timescale 1ns/1ps
`include "excp_defs.svh"

module csr_file (
    input  logic                        clk,
    input  logic                        reset,
    output excp_pkg::csr_t              rd_csr,
    input  excp_pkg::excp_wr_csr_req_t  wr_csr_req,
    input  logic [`IS_W-1:0]            is,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`XLEN-1:0]            paddr,
    input  logic [`XLEN-1:0]            pwdata,
    output logic [`XLEN-1:0]            prdata,
    output logic                        pready,
    output logic                        pslverr
);

    excp_pkg::csr_t    csr_q;
    excp_pkg::csr_word_u wr_word;
    excp_pkg::csr_word_u rd_word;
    logic [13:0]       csr_num;
    logic              addr_hit;
    logic              addr_ok;
    logic              apb_wr;

    // ******************************
    // CSR view
    // ******************************

    always_comb begin
        rd_csr          = csr_q;
        rd_csr.estat.is = is;                   // Status lives in the exception unit
    end

    // ******************************
    // APB decode
    // ******************************

    assign csr_num = paddr[15:2];

    always_comb begin
        addr_hit    = 1'b1;
        rd_word.raw = '0;
        case (csr_num)
            `CSR_CRMD:      rd_word.crmd  = rd_csr.crmd;
            `CSR_PRMD:      rd_word.prmd  = rd_csr.prmd;
            `CSR_ECFG:      rd_word.ecfg  = rd_csr.ecfg;
            `CSR_ESTAT:     rd_word.estat = rd_csr.estat;
            `CSR_ERA:       rd_word.raw   = rd_csr.era;
            `CSR_BADV:      rd_word.raw   = rd_csr.badv;
            `CSR_EENTRY:    rd_word.raw   = rd_csr.eentry;
            `CSR_TLBRENTRY: rd_word.raw   = rd_csr.tlbrentry;
            default:        addr_hit      = 1'b0;
        endcase
    end

    // Only word-aligned numbers below the 16-bit window are CSRs
    assign addr_ok = addr_hit & (paddr[`XLEN-1:16] == '0) & (paddr[1:0] == 2'b00);

    // An exception write takes the CSRs this cycle, so the access waits one cycle
    assign pready  = psel & penable & ~wr_csr_req.we;
    assign pslverr = pready & ~addr_ok;
    assign prdata  = rd_word.raw;

    assign apb_wr      = pready & pwrite & addr_ok;
    assign wr_word.raw = pwdata;

    // ******************************
    // CSR storage
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_q          <= '0;
            csr_q.crmd.plv <= excp_pkg::KERNEL;
        end else if (wr_csr_req.we) begin
            csr_q.crmd                   <= wr_csr_req.crmd;
            csr_q.prmd                   <= wr_csr_req.prmd;
            csr_q.estat.r_esubcode_ecode <= wr_csr_req.estat.r_esubcode_ecode;
            csr_q.era                    <= wr_csr_req.era;
        end else if (apb_wr) begin
            case (csr_num)
                `CSR_CRMD: begin
                    csr_q.crmd.plv <= wr_word.crmd.plv;
                    csr_q.crmd.ie  <= wr_word.crmd.ie;
                end
                `CSR_PRMD: begin
                    csr_q.prmd.pplv <= wr_word.prmd.pplv;
                    csr_q.prmd.pie  <= wr_word.prmd.pie;
                end
                `CSR_ECFG: begin
                    csr_q.ecfg.lie <= wr_word.ecfg.lie;
                end
                `CSR_ERA: begin
                    csr_q.era <= wr_word.raw;
                end
                `CSR_BADV: begin
                    csr_q.badv <= wr_word.raw;
                end
                `CSR_EENTRY: begin
                    csr_q.eentry <= {wr_word.raw[`XLEN-1:6], 6'b0};    // 64-byte entry
                end
                `CSR_TLBRENTRY: begin
                    csr_q.tlbrentry <= {wr_word.raw[`XLEN-1:6], 6'b0};
                end
                default: begin
                    // ESTAT is read-only from software
                end
            endcase
        end
    end

endmodule

//--- excp_subsys.sv
`timescale 1ns/1ps
`include "excp_defs.svh"

module excp_subsys (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  retire_valid,
    input  excp_pkg::virt_t       retire_pc,
    input  excp_pkg::excp_pass_t  retire_excp,
    input  logic [7:0]            hwi_in,
    input  logic                  ti_in,
    input  logic                  ti_clr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`XLEN-1:0]      paddr,
    input  logic [`XLEN-1:0]      pwdata,
    output logic [`XLEN-1:0]      prdata,
    output logic                  pready,
    output logic                  pslverr,
    output excp_pkg::wr_pc_req_t  wr_pc_req,
    output logic                  excp_flush
);

    excp_pkg::excp_req_t         req;
    excp_pkg::excp_wr_csr_req_t  wr_csr_req;
    excp_pkg::csr_t              rd_csr;
    logic [`IS_W-1:0]            int_status;

    retire_stage u_retire_stage (
        .clk         (clk),
        .reset       (reset),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_excp (retire_excp),
        .excp_flush  (excp_flush),
        .req         (req)
    );

    excp_unit u_excp_unit (
        .clk        (clk),
        .reset      (reset),
        .ti_in      (ti_in),
        .ti_clr     (ti_clr),
        .hwi_in     (hwi_in),
        .req        (req),
        .rd_csr     (rd_csr),
        .wr_pc_req  (wr_pc_req),
        .excp_flush (excp_flush),
        .wr_csr_req (wr_csr_req),
        .is         (int_status)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .reset      (reset),
        .rd_csr     (rd_csr),
        .wr_csr_req (wr_csr_req),
        .is         (int_status),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

endmodule

//--- tb_excp_subsys.sv
`timescale 1ns/1ps
`include "excp_defs.svh"

module tb_excp_subsys;

    localparam int TIMEOUT = 16;                // Cycles allowed for one APB access

    logic                 clk;
    logic                 reset;
    logic                 retire_valid;
    excp_pkg::virt_t      retire_pc;
    excp_pkg::excp_pass_t retire_excp;
    logic [7:0]           hwi_in;
    logic                 ti_in;
    logic                 ti_clr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [`XLEN-1:0]     paddr;
    logic [`XLEN-1:0]     pwdata;
    logic [`XLEN-1:0]     prdata;
    logic                 pready;
    logic                 pslverr;
    excp_pkg::wr_pc_req_t wr_pc_req;
    logic                 excp_flush;

    excp_subsys DUT (.*);

    always #20 clk = ~clk;

    // ******************************
    // Compare tasks
    // ******************************

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_flush(input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("error at %0t: excp_flush expected %b got %b", $time, exp, act));
        end
    endtask

    task automatic check_pc_req(input excp_pkg::wr_pc_req_t exp, input excp_pkg::wr_pc_req_t act);
        if (act.valid !== exp.valid) begin
            fail_run($sformatf("error at %0t: wr_pc_req.valid expected %b got %b",
                               $time, exp.valid, act.valid));
        end
        if (exp.valid && act.pc !== exp.pc) begin
            fail_run($sformatf("error at %0t: wr_pc_req.pc expected %h got %h",
                               $time, exp.pc, act.pc));
        end
    endtask

    task automatic check_rdata(input logic [`XLEN-1:0] exp_data, input logic exp_err,
                               input logic [`XLEN-1:0] act_data, input logic act_err,
                               input logic with_data);
        if (act_err !== exp_err) begin
            fail_run($sformatf("error at %0t: pslverr expected %b got %b",
                               $time, exp_err, act_err));
        end
        if (with_data && act_data !== exp_data) begin
            fail_run($sformatf("error at %0t: prdata expected %h got %h",
                               $time, exp_data, act_data));
        end
    endtask

    // ******************************
    // Drivers
    // ******************************

    task automatic idle_retire();
        retire_valid      = 1'b0;
        retire_pc         = $urandom;           // Filler PC, never retired
        retire_excp.valid = 1'b0;
    endtask

    // Samples pready just after the falling edge, once the access phase is driven
    task automatic wait_ready(output int waits);
        waits = 0;
        #1;
        while (!pready && waits < TIMEOUT) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (!pready) begin
            fail_run("APB access did not complete within the timeout");
        end
    endtask

    task automatic apb_access(input logic write, input logic [`XLEN-1:0] addr,
                              input logic [`XLEN-1:0] wdata,
                              output logic [`XLEN-1:0] rdata, output logic err);
        int waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        wait_ready(waits);
        if (waits != 0) begin
            fail_run($sformatf("APB access took %0d wait cycles with no exception", waits));
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // The redirect is due one cycle after the retire input
    task automatic retire(input excp_pkg::virt_t pc, input logic valid, input logic ev,
                          input logic [14:0] ecode, input logic exp_flush,
                          input excp_pkg::virt_t exp_pc);
        excp_pkg::wr_pc_req_t exp_req;
        @(negedge clk);
        retire_valid                   = valid;
        retire_pc                      = pc;
        retire_excp.valid              = ev;
        retire_excp.esubcode_ecode     = excp_pkg::ecode_t'(ecode);
        @(negedge clk);
        exp_req.valid = exp_flush;
        exp_req.pc    = exp_pc;
        check_flush(exp_flush, excp_flush);
        check_pc_req(exp_req, wr_pc_req);
        idle_retire();
    endtask

    // Access phase lands on the flush cycle, so the read stalls once and sees the new CSR
    task automatic read_during_trap(input excp_pkg::virt_t pc, input logic [14:0] ecode,
                                    input logic [`XLEN-1:0] addr,
                                    input logic [`XLEN-1:0] exp_data);
        int waits;
        @(negedge clk);
        retire_valid               = 1'b1;
        retire_pc                  = pc;
        retire_excp.valid          = 1'b1;
        retire_excp.esubcode_ecode = excp_pkg::ecode_t'(ecode);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        check_flush(1'b1, excp_flush);
        idle_retire();
        penable = 1'b1;
        wait_ready(waits);
        if (waits != 1) begin
            fail_run($sformatf("APB read during an exception took %0d wait cycles, not 1", waits));
        end
        check_rdata(exp_data, 1'b0, prdata, pslverr, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // ******************************
    // Pattern run
    // ******************************

    initial begin
        int                fd;
        int                n;
        int                gap;
        int unsigned       seed_val;
        logic [7:0]        op;
        logic [`XLEN-1:0]  a, b, c, d, e, f;
        logic [`XLEN-1:0]  rdata;
        logic              err;
        string             line;
        clk          = 1'b0;
        reset        = 1'b1;
        retire_valid = 1'b0;
        retire_pc    = '0;
        retire_excp  = '0;
        hwi_in       = '0;
        ti_in        = 1'b0;
        ti_clr       = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        seed_val     = 32'h2317;
        n            = $urandom(seed_val);
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_flush(1'b0, excp_flush);
        fd = $fopen("excp_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open excp_patterns.txt");
        end
        n = $fscanf(fd, " %c", op);
        while (n == 1) begin
            case (op)
                "#": n = $fgets(line, fd);
                "W": begin
                    n = $fscanf(fd, " %h %h %h", a, b, c);
                    apb_access(1'b1, a, b, rdata, err);
                    check_rdata('0, c[0], rdata, err, 1'b0);
                end
                "R": begin
                    n = $fscanf(fd, " %h %h %h", a, b, c);
                    apb_access(1'b0, a, '0, rdata, err);
                    check_rdata(b, c[0], rdata, err, 1'b1);
                end
                "X": begin
                    n = $fscanf(fd, " %h %h %h %h %h %h", a, b, c, d, e, f);
                    retire(a, b[0], c[0], d[14:0], e[0], f);
                end
                "S": begin
                    n = $fscanf(fd, " %h %h %h %h", a, b, c, d);
                    read_during_trap(a, b[14:0], c, d);
                end
                "I": begin
                    n = $fscanf(fd, " %h %h", a, b);
                    @(negedge clk);
                    hwi_in = a[7:0];
                    ti_in  = b[0];
                end
                "C": begin
                    @(negedge clk);
                    ti_clr = 1'b1;
                    @(negedge clk);
                    ti_clr = 1'b0;
                end
                default: fail_run($sformatf("unknown operation %c in the pattern file", op));
            endcase
            gap = $urandom % 4;
            repeat (gap) begin
                @(negedge clk);
                idle_retire();
            end
            n = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
excp_pkg.sv
retire_stage.sv
excp_unit.sv
csr_file.sv
excp_subsys.sv
tb_excp_subsys.sv

//--- excp_patterns.txt
# W addr data exp_err | R addr exp_data exp_err | I hwi ti | C (timer clear)
# X pc valid excp_valid ecode exp_flush exp_pc | S pc ecode addr exp_data (read during trap)
W 00000030 1c001234 0
R 00000030 1c001200 0
W 00000220 1c00ffff 0
R 00000220 1c00ffc0 0
W 00000010 ffffffff 0
R 00000010 00001fff 0
W 00000000 ffffffff 0
R 00000000 00000007 0
W 00000040 12345678 1
R 00000040 00000000 1
R 00000000 00000007 0
X 1c008000 1 1 000b 1 1c001200
R 00000018 1c008000 0
R 00000014 000b0000 0
R 00000000 00000000 0
R 00000004 00000007 0
X 1c008010 1 1 003f 1 1c00ffc0
R 00000014 003f0000 0
I 01 0
X 1c008020 1 0 0000 0 00000000
W 00000000 00000004 0
W 00000010 00000000 0
X 1c008030 1 0 0000 0 00000000
W 00000010 00000004 0
X 1c008040 1 1 000c 1 1c001200
R 00000014 00000004 0
R 00000018 1c008040 0
R 00000004 00000004 0
I 00 1
I 00 0
R 00000014 00000804 0
C
R 00000014 00000004 0
S 1c0080a0 000b 00000018 1c0080a0
R 00000014 000b0004 0
X 1c0080b0 0 1 000b 0 00000000
